/* tests/acc_input.txt */
# name instr(hex) acc(hex) carry zero busy
# busy 1 means the strobe is given while the previous instruction runs
reset_nop 00 00 0 1 0
ldi_5     85 05 0 0 0
sta_m3    23 05 0 0 0
ldi_c     8C 0C 0 0 0
sta_m7    27 0C 0 0 0
set_a     C0 FF 0 0 0
sta_m9    29 FF 0 0 0
lda_m7    17 0C 0 0 0
lda_m9    19 FF 0 0 0
lda_m3    13 05 0 0 0
add_m3    33 0A 0 0 0
add_cy    39 09 1 0 0
sub_bw    47 FD 1 0 0
shl0_f1   98 FD 1 0 0
shr1_f0   A1 7E 1 0 0
shr3_f1   AB EF 1 0 0
shl1_f0   91 DE 1 0 0
shr7_f0   A7 01 1 0 0
shl7_f1   9F FF 1 0 0
sub_m3    43 FA 0 0 0
and_m7    57 08 0 0 0
or_m3     63 0D 0 0 0
xor_m7    77 01 0 0 0
ldi_5b    85 05 0 0 0
sub_zero  43 00 0 1 0
set_b     C0 FF 0 0 0
clr_a     B0 00 0 1 0
ldi_3     83 03 0 0 0
busy_ldi  8A 03 0 0 1
set_c     C0 FF 0 0 0
busy_clr  B0 FF 0 0 1
nop_a     00 FF 0 0 0

/* verilog.f */
source/acc_pkg.sv
source/acc_shift_reg.sv
source/acc_alu.sv
source/acc_data_mem.sv
source/acc_control.sv
source/acc_top.sv
tests/acc_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the accumulator core testbench with Verilator

LOG=sim.log
BUILD_DIR=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
	--top-module acc_top_tb -Mdir "$BUILD_DIR" -o acc_top_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/acc_top_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* tests/acc_top_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module acc_top_tb;
	import acc_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 3;
	localparam int DRIVE_DLY  = 2;   // Input skew after rising edge
	localparam int MAX_VEC    = 64;
	localparam int DONE_LIMIT = 8;   // Edges to wait for done before giving up
	localparam logic [127:0] COMMENT_TOK = 128'h23; // Lone "#" token

	logic   clk;
	logic   rst_n;
	logic   instr_strobe;
	instr_t instr;
	data_t  acc;
	logic   carry;
	logic   zero;
	logic   busy;
	logic   done;

	// Vector table filled once from the input file
	string  vec_name  [MAX_VEC];
	instr_t vec_instr [MAX_VEC];
	data_t  vec_acc   [MAX_VEC];
	logic   vec_carry [MAX_VEC];
	logic   vec_zero  [MAX_VEC];
	logic   vec_busy  [MAX_VEC];   // Strobe lands while the previous instruction runs
	int     n_vec;
	int     val_errs;
	int     proto_errs;
	logic   loaded;

	acc_top acc_top_i (
		.clk, .rst_n, .instr_strobe, .instr,
		.acc, .carry, .zero, .busy, .done
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Vector file reader
	//////////////////////////////////////////////////////////////////////
	task automatic load_vectors();
		int           fd;
		int           r;
		logic [127:0] tok;
		logic [1023:0] rest;
		instr_t       f_instr;
		data_t        f_acc;
		logic         f_carry;
		logic         f_zero;
		logic         f_busy;
		fd = $fopen("tests/acc_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open tests/acc_input.txt");
			proto_errs++;
			return;
		end
		r = $fscanf(fd, "%s", tok);
		while (r == 1 && n_vec < MAX_VEC) begin
			if (tok == COMMENT_TOK) begin
				r = $fgets(rest, fd);   // Skip column notes
				r = 1;
			end else begin
				r = $fscanf(fd, "%h %h %h %h %h", f_instr, f_acc, f_carry, f_zero, f_busy);
				if (r != 5) begin
					$display("Malformed vector line starting with %0s", string'(tok));
					proto_errs++;
				end else begin
					vec_name[n_vec]  = string'(tok);
					vec_instr[n_vec] = f_instr;
					vec_acc[n_vec]   = f_acc;
					vec_carry[n_vec] = f_carry;
					vec_zero[n_vec]  = f_zero;
					vec_busy[n_vec]  = f_busy;
					n_vec++;
					r = 1;
				end
			end
			if (r == 1)
				r = $fscanf(fd, "%s", tok);
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Instruction driver and result checks
	//////////////////////////////////////////////////////////////////////

	// Called 2 ns after an edge with busy low so that edge k samples the strobe
	task automatic run_instr(input int idx);
		int   edges;
		logic seen;
		instr        = vec_instr[idx];
		instr_strobe = 1'b1;
		@(posedge clk);                 // Edge k
		#DRIVE_DLY;
		instr_strobe = 1'b0;
		if (busy !== 1'b1) begin
			$display("busy did not rise after the strobe for %0s", vec_name[idx]);
			proto_errs++;
		end
		if (idx + 1 < n_vec && vec_busy[idx + 1]) begin
			instr        = vec_instr[idx + 1]; // Sampled at edge k+1 while the core is busy
			instr_strobe = 1'b1;
		end
		edges = 0;
		seen  = 1'b0;
		while (!seen && edges < DONE_LIMIT) begin
			@(posedge clk);
			#DRIVE_DLY;
			instr_strobe = 1'b0;
			edges++;
			seen = (done === 1'b1);
		end
		if (!seen) begin
			$display("No done pulse for %0s within %0d cycles", vec_name[idx], DONE_LIMIT);
			proto_errs++;
		end else if (edges != 2) begin
			$display("done for %0s came %0d edges after acceptance, not 2", vec_name[idx], edges);
			proto_errs++;
		end
		if (seen && busy !== 1'b0) begin
			$display("busy still high while done pulses for %0s", vec_name[idx]);
			proto_errs++;
		end
	endtask

	// Ignored strobe must give no completion and leave the core idle
	task automatic watch_ignored(input int idx);
		logic stray;
		stray = 1'b0;
		repeat (3) begin
			@(posedge clk);
			#DRIVE_DLY;
			if (done !== 1'b0 || busy !== 1'b0)
				stray = 1'b1;
		end
		if (stray) begin
			$display("Strobe given while busy was taken for %0s", vec_name[idx]);
			proto_errs++;
		end
	endtask

	task automatic compare_result(input int idx);
		if (acc !== vec_acc[idx]) begin
			$display("ERR %0s acc expected %02h actual %02h", vec_name[idx], vec_acc[idx], acc);
			val_errs++;
		end
		if (carry !== vec_carry[idx]) begin
			$display("ERR %0s carry expected %0b actual %0b", vec_name[idx], vec_carry[idx], carry);
			val_errs++;
		end
		if (zero !== vec_zero[idx]) begin
			$display("ERR %0s zero expected %0b actual %0b", vec_name[idx], vec_zero[idx], zero);
			val_errs++;
		end
	endtask

	// Watchdog budget of 10 cycles per vector plus reset
	initial begin
		wait (loaded);
		#((n_vec * 10 + RST_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired before all vectors were run");
		$display("Error counts: value %0d, protocol %0d", val_errs, proto_errs);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		rst_n        = 1'b0;
		instr_strobe = 1'b0;
		instr        = '0;
		n_vec        = 0;
		val_errs     = 0;
		proto_errs   = 0;
		loaded       = 1'b0;
		load_vectors();
		if (n_vec == 0) begin
			$display("No vectors were read");
			proto_errs++;
		end
		loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		if (busy !== 1'b0 || done !== 1'b0) begin
			$display("busy or done not low after reset");
			proto_errs++;
		end
		for (int i = 0; i < n_vec; i++) begin
			if (vec_busy[i])
				watch_ignored(i);   // Its strobe went out during the previous run
			else
				run_instr(i);
			compare_result(i);
		end
		$display("Error counts: value %0d, protocol %0d", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* source/acc_top.sv */
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Accumulator core top level
//////////////////////////////////////////////////////////////////////

module acc_top (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            instr_strobe, // One-cycle pulse
	input  wire acc_pkg::instr_t instr,
	output acc_pkg::data_t       acc,
	output logic                 carry,
	output logic                 zero,
	output logic                 busy,
	output logic                 done
);
	import acc_pkg::*;

	addr_t     mem_addr;
	logic      mem_we;
	opcode_t   alu_op;
	shift_op_t shift_ctrl;
	shamt_t    shamt;
	logic      fill;
	logic      clr_n;
	logic      set_n;
	data_t     rd_data;     // Memory word into ALU
	data_t     alu_result;  // Load value for accumulator
	logic      carry_next;

	assign zero = ~|acc;

	acc_control acc_control_i (
		.clk, .rst_n, .instr_strobe, .instr, .carry_next,
		.mem_addr, .mem_we, .alu_op, .shift_ctrl, .shamt, .fill,
		.clr_n, .set_n, .carry, .busy, .done
	);

	acc_alu acc_alu_i (
		.alu_op,
		.acc,
		.operand (rd_data),
		.imm     (mem_addr),   // Operand field is also the immediate
		.alu_result,
		.carry_next
	);

	acc_data_mem acc_data_mem_i (
		.clk,
		.addr    (mem_addr),
		.we      (mem_we),
		.wr_data (acc),        // STA writes the accumulator
		.rd_data
	);

	acc_shift_reg acc_shift_reg_i (
		.clk, .rst_n, .clr_n, .set_n, .fill, .shift_ctrl, .shamt,
		.load_data (alu_result),
		.acc
	);

endmodule

`default_nettype wire

/* source/acc_control.sv */
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Control sequencer
// IDLE -> READ -> EXEC -> IDLE, one instruction at a time
//////////////////////////////////////////////////////////////////////

module acc_control (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             instr_strobe,
	input  wire acc_pkg::instr_t  instr,
	input  wire logic             carry_next,   // From ALU
	output acc_pkg::addr_t        mem_addr,
	output logic                  mem_we,
	output acc_pkg::opcode_t      alu_op,
	output acc_pkg::shift_op_t    shift_ctrl,
	output acc_pkg::shamt_t       shamt,
	output logic                  fill,
	output logic                  clr_n,
	output logic                  set_n,
	output logic                  carry,
	output logic                  busy,
	output logic                  done
);
	import acc_pkg::*;

	ctrl_state_t state, state_nxt;
	opcode_t     op_q;        // Latched opcode
	addr_t       operand_q;   // Latched operand field
	logic        accept;
	logic        carry_upd;

	assign accept = instr_strobe && (state == ST_IDLE); // Strobes while busy dropped
	assign busy   = (state != ST_IDLE);

	// Operand fields fan out directly
	assign mem_addr = operand_q;
	assign alu_op   = op_q;
	assign shamt    = operand_q[2:0];
	assign fill     = operand_q[3];

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (state)
			ST_IDLE: state_nxt = accept ? ST_READ : ST_IDLE;
			ST_READ: state_nxt = ST_EXEC;   // Memory read lands here
			ST_EXEC: state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			done  <= 1'b0;
			carry <= 1'b0;
		end else begin
			state <= state_nxt;
			done  <= (state == ST_EXEC); // One-cycle pulse after execute
			if (carry_upd)
				carry <= carry_next;
		end
	end

	// Instruction latch
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q      <= opcode_t'(instr[7:4]);
			operand_q <= instr[3:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Execute decode, all controls idle outside ST_EXEC
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		shift_ctrl = SH_HOLD;
		clr_n      = 1'b1;
		set_n      = 1'b1;
		mem_we     = 1'b0;
		carry_upd  = 1'b0;
		if (state == ST_EXEC) begin
			case (op_q)
				OP_LDA, OP_AND, OP_OR, OP_XOR, OP_LDI: shift_ctrl = SH_LOAD;
				OP_ADD, OP_SUB: begin
					shift_ctrl = SH_LOAD;
					carry_upd  = 1'b1;  // Only arithmetic touches carry
				end
				OP_STA: mem_we = 1'b1;
				OP_SHL: shift_ctrl = SH_LEFT;
				OP_SHR: shift_ctrl = SH_RIGHT;
				OP_CLR: clr_n = 1'b0;
				OP_SET: set_n = 1'b0;
				default: shift_ctrl = SH_HOLD; // NOP and unused codes
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/acc_data_mem.sv */
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Data memory, 16 x 8
// One cycle read latency
//////////////////////////////////////////////////////////////////////

module acc_data_mem (
	input  wire logic           clk,
	input  wire acc_pkg::addr_t addr,
	input  wire logic           we,
	input  wire acc_pkg::data_t wr_data,
	output acc_pkg::data_t      rd_data
);
	import acc_pkg::*;

	localparam int DEPTH = 2 ** ADDR_W;

	data_t mem [DEPTH]; // Contents undefined until written

	// Write commits on the edge where we is high
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wr_data;
		end
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge clk) begin
		rd_data <= mem[addr];
	end

endmodule

`default_nettype wire

/* source/acc_alu.sv */
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// ALU, purely combinational
// Result feeds the accumulator load input
//////////////////////////////////////////////////////////////////////

module acc_alu (
	input  wire acc_pkg::opcode_t alu_op,
	input  wire acc_pkg::data_t   acc,
	input  wire acc_pkg::data_t   operand,   // Memory word
	input  wire acc_pkg::addr_t   imm,       // Operand field for LDI
	output acc_pkg::data_t        alu_result,
	output logic                  carry_next
);
	import acc_pkg::*;

	logic [DATA_W:0] sum_w;  // Extra bit holds carry out
	logic [DATA_W:0] diff_w; // Extra bit holds borrow

	assign sum_w  = {1'b0, acc} + {1'b0, operand};
	assign diff_w = {1'b0, acc} - {1'b0, operand}; // MSB set when operand > acc

	always_comb begin
		alu_result = acc;   // Default, acc passes through
		carry_next = 1'b0;
		case (alu_op)
			OP_ADD: begin
				alu_result = sum_w[DATA_W-1:0];
				carry_next = sum_w[DATA_W];
			end
			OP_SUB: begin
				alu_result = diff_w[DATA_W-1:0];
				carry_next = diff_w[DATA_W];  // Borrow
			end
			OP_AND: alu_result = acc & operand;
			OP_OR:  alu_result = acc | operand;
			OP_XOR: alu_result = acc ^ operand;
			OP_LDA: alu_result = operand;     // Memory word straight through

			// Zero extend the 4-bit immediate
			OP_LDI: alu_result = {{(DATA_W-ADDR_W){1'b0}}, imm};
			default: begin
				alu_result = acc;
				carry_next = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/acc_shift_reg.sv */
`timescale 1ns/100ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Accumulator register
// Priority: clr_n, then set_n, then shift_ctrl
//////////////////////////////////////////////////////////////////////

module acc_shift_reg (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              clr_n,      // Sync clear, active low
	input  wire logic              set_n,      // Sync set, active low
	input  wire logic              fill,       // Bit shifted into vacated positions
	input  wire acc_pkg::shift_op_t shift_ctrl,
	input  wire acc_pkg::shamt_t    shamt,
	input  wire acc_pkg::data_t     load_data,
	output acc_pkg::data_t          acc
);
	import acc_pkg::*;

	data_t fill_word;   // Fill bit replicated across the word
	data_t left_mask;   // Low shamt bits set
	data_t right_mask;  // High shamt bits set
	data_t shl_val;
	data_t shr_val;

	assign fill_word = {DATA_W{fill}};

	// Masks mark the positions vacated by the shift
	assign left_mask  = ~({DATA_W{1'b1}} << shamt);
	assign right_mask = ~({DATA_W{1'b1}} >> shamt);

	// Whole shift in one edge, zero count leaves acc as is
	assign shl_val = (acc << shamt) | (left_mask & fill_word);
	assign shr_val = (acc >> shamt) | (right_mask & fill_word);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (!clr_n) begin
			acc <= '0;                 // Clear wins over everything
		end else if (!set_n) begin
			acc <= '1;                 // Set wins over control code
		end else begin
			case (shift_ctrl)
				SH_HOLD:  acc <= acc;
				SH_LOAD:  acc <= load_data; // From ALU
				SH_LEFT:  acc <= shl_val;
				SH_RIGHT: acc <= shr_val;
				default:  acc <= acc;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/acc_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Shared types and encodings for the accumulator core
//////////////////////////////////////////////////////////////////////

package acc_pkg;

	localparam int DATA_W = 8; // Accumulator and memory word width
	localparam int ADDR_W = 4; // Operand field doubles as memory address

	typedef logic [DATA_W-1:0] data_t;  // Accumulator / memory word
	typedef logic [ADDR_W-1:0] addr_t;  // Data memory address
	typedef logic [7:0]        instr_t; // {opcode, operand}
	typedef logic [2:0]        shamt_t; // Shift count, 0 to 7

	// Upper nibble of the instruction
	typedef enum logic [3:0] {
		OP_NOP = 4'h0, // No effect
		OP_LDA = 4'h1, // acc <= mem[op]
		OP_STA = 4'h2, // mem[op] <= acc
		OP_ADD = 4'h3, // acc <= acc + mem[op], carry out
		OP_SUB = 4'h4, // acc <= acc - mem[op], borrow
		OP_AND = 4'h5,
		OP_OR  = 4'h6,
		OP_XOR = 4'h7,
		OP_LDI = 4'h8, // acc <= zero-extended operand
		OP_SHL = 4'h9, // Count in op[2:0], fill in op[3]
		OP_SHR = 4'hA,
		OP_CLR = 4'hB, // All zeros
		OP_SET = 4'hC  // All ones
	} opcode_t;

	// Accumulator register control code
	typedef enum logic [1:0] {
		SH_HOLD  = 2'b00, // Keep value
		SH_LOAD  = 2'b01, // Parallel load
		SH_LEFT  = 2'b10, // Multi-bit left shift
		SH_RIGHT = 2'b11  // Multi-bit right shift
	} shift_op_t;

	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_EXEC} ctrl_state_t;

endpackage

`default_nettype wire
